// File: cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`default_nettype none

// data and address width
`define WORD_SIZE 16

`define REG_COUNT   4
`define QUEUE_DEPTH 4

// instruction fields
`define OPCODE_HI 15
`define OPCODE_LO 12
`define RS_POS    10   // rs in [11:10]
`define RT_POS    8    // rt in [9:8]
`define RD_POS    6    // rd in [7:6], func below it

// immediate sits in the low byte
`define IMM_SIZE 8

`default_nettype wire

`endif

// File: cpu_pkg.sv
`include "cpu_macros.svh"
`default_nettype none

package cpu_pkg;

    typedef logic [`WORD_SIZE-1:0]         word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;
    typedef logic [`IMM_SIZE-1:0]          imm_t;

    typedef enum logic [3:0] {
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_RTYPE = 4'd15
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_TCP = 6'd5,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } func_e;

    // same order as the low bits of the R-type function codes
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_ORR,
        ALU_NOT,
        ALU_TCP,
        ALU_SHL,
        ALU_SHR
    } alu_op_e;

    //////////////////////////////
    // field extraction

    function automatic opcode_e get_opcode(word_t w);
        return opcode_e'(w[`OPCODE_HI:`OPCODE_LO]);
    endfunction

    function automatic reg_idx_t get_reg(word_t w, int unsigned pos);
        return reg_idx_t'(w >> pos);
    endfunction

    function automatic func_e get_func(word_t w);
        return func_e'(w[`RD_POS-1:0]);
    endfunction

    function automatic imm_t get_imm(word_t w);
        return w[`IMM_SIZE-1:0];
    endfunction

endpackage

`default_nettype wire

// File: alu.sv
`include "cpu_macros.svh"
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  wire cpu_pkg::alu_op_e alu_op,
    input  wire cpu_pkg::word_t   alu_a,
    input  wire cpu_pkg::word_t   alu_b,
    output cpu_pkg::word_t        alu_result
);

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_ADD: begin
                alu_result = alu_a + alu_b;
            end
            cpu_pkg::ALU_SUB: begin
                alu_result = alu_a - alu_b;
            end
            cpu_pkg::ALU_AND: begin
                alu_result = alu_a & alu_b;
            end
            cpu_pkg::ALU_ORR: begin
                alu_result = alu_a | alu_b;
            end
            cpu_pkg::ALU_NOT: begin
                alu_result = ~alu_a;
            end
            cpu_pkg::ALU_TCP: begin
                alu_result = ~alu_a + `WORD_SIZE'(1);   // negate
            end
            cpu_pkg::ALU_SHL: begin
                alu_result = {alu_a[`WORD_SIZE-2:0], 1'b0};
            end
            cpu_pkg::ALU_SHR: begin
                // arithmetic, sign bit kept
                alu_result = {alu_a[`WORD_SIZE-1], alu_a[`WORD_SIZE-1:1]};
            end
            default: begin
                alu_result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: inst_fetch.sv
`include "cpu_macros.svh"
`timescale 1ns/10ps
`default_nettype none

module inst_fetch (
    input  wire                  clk,
    input  wire                  reset_n,
    input  wire                  m1_ready,
    input  wire cpu_pkg::word_t  data1,
    input  wire                  fetch_ready,
    output logic                 read_m1,
    output cpu_pkg::word_t       address1,
    output logic                 fetch_valid,
    output cpu_pkg::word_t       fetch_word
);

    cpu_pkg::word_t pc;
    logic           slot_valid;
    cpu_pkg::word_t slot_word;
    logic           slot_take;
    logic           read_done;

    // slot handed to the queue this cycle
    assign slot_take = slot_valid & fetch_ready;

    // only ask for a word when there is room for it
    assign read_m1   = ~reset_n & (~slot_valid | fetch_ready);
    assign read_done = read_m1 & m1_ready;

    assign address1    = pc;
    assign fetch_valid = slot_valid;
    assign fetch_word  = slot_word;

    //////////////////////////////
    // program counter and slot

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc         <= '0;
            slot_valid <= 1'b0;
        end else begin
            if (read_done) begin
                pc         <= pc + `WORD_SIZE'(1);
                slot_valid <= 1'b1;       // refill, even when drained now
            end else if (slot_take) begin
                slot_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (read_done) begin
            slot_word <= data1;
        end
    end

endmodule

`default_nettype wire

// File: inst_queue.sv
`include "cpu_macros.svh"
`timescale 1ns/10ps
`default_nettype none

module inst_queue (
    input  wire                  clk,
    input  wire                  reset_n,
    input  wire                  fetch_valid,
    input  wire cpu_pkg::word_t  fetch_word,
    input  wire                  inst_ready,
    output logic                 fetch_ready,
    output logic                 inst_valid,
    output cpu_pkg::word_t       inst_word
);

    localparam int DEPTH = `QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    cpu_pkg::word_t   buf_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // full means no push, a pop in the same cycle does not help
    assign fetch_ready = (count != CNT_W'(DEPTH));
    assign inst_valid  = (count != '0);
    assign inst_word   = buf_mem[rd_ptr];

    assign push = fetch_valid & fetch_ready;
    assign pop  = inst_valid & inst_ready;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_next(wr_ptr);
            if (pop)  rd_ptr <= ptr_next(rd_ptr);
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            buf_mem[wr_ptr] <= fetch_word;
        end
    end

endmodule

`default_nettype wire

// File: exec_unit.sv
`include "cpu_macros.svh"
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
    input  wire                  clk,
    input  wire                  reset_n,
    input  wire                  inst_valid,
    input  wire cpu_pkg::word_t  inst_word,
    output logic                 inst_ready,
    output cpu_pkg::word_t       num_inst,
    output cpu_pkg::word_t       output_port,
    output logic                 is_halted
);

    localparam int EXT_W = `WORD_SIZE - `IMM_SIZE;

    cpu_pkg::word_t    regs [`REG_COUNT];
    cpu_pkg::opcode_e  opcode;
    cpu_pkg::func_e    func;
    cpu_pkg::reg_idx_t rs;
    cpu_pkg::reg_idx_t rt;
    cpu_pkg::reg_idx_t rd;
    cpu_pkg::imm_t     imm;
    cpu_pkg::word_t    rs_val;
    cpu_pkg::word_t    rt_val;
    cpu_pkg::alu_op_e  alu_op;
    cpu_pkg::word_t    alu_a;
    cpu_pkg::word_t    alu_b;
    cpu_pkg::word_t    alu_result;
    cpu_pkg::reg_idx_t wr_idx;
    logic              wr_en;
    logic              is_wwd;
    logic              is_hlt;
    logic              retire;

    //////////////////////////////
    // decode

    assign opcode = cpu_pkg::get_opcode(inst_word);
    assign func   = cpu_pkg::get_func(inst_word);
    assign rs     = cpu_pkg::get_reg(inst_word, `RS_POS);
    assign rt     = cpu_pkg::get_reg(inst_word, `RT_POS);
    assign rd     = cpu_pkg::get_reg(inst_word, `RD_POS);
    assign imm    = cpu_pkg::get_imm(inst_word);

    assign rs_val = regs[rs];
    assign rt_val = regs[rt];

    assign inst_ready = ~is_halted;      // stop consuming after HLT
    assign retire     = inst_valid & inst_ready;

    always_comb begin
        alu_op = cpu_pkg::ALU_ADD;
        alu_a  = rs_val;
        alu_b  = rt_val;
        wr_en  = 1'b0;
        wr_idx = rd;
        is_wwd = 1'b0;
        is_hlt = 1'b0;
        case (opcode)
            cpu_pkg::OP_ADI: begin
                alu_b  = {{EXT_W{imm[`IMM_SIZE-1]}}, imm};
                wr_en  = 1'b1;
                wr_idx = rt;
            end
            cpu_pkg::OP_ORI: begin
                alu_op = cpu_pkg::ALU_ORR;
                alu_b  = {{EXT_W{1'b0}}, imm};
                wr_en  = 1'b1;
                wr_idx = rt;
            end
            cpu_pkg::OP_LHI: begin
                alu_op = cpu_pkg::ALU_ORR;   // 0 | imm<<8
                alu_a  = '0;
                alu_b  = {imm, {EXT_W{1'b0}}};
                wr_en  = 1'b1;
                wr_idx = rt;
            end
            cpu_pkg::OP_RTYPE: begin
                case (func)
                    cpu_pkg::FN_ADD, cpu_pkg::FN_SUB, cpu_pkg::FN_AND, cpu_pkg::FN_ORR,
                    cpu_pkg::FN_NOT, cpu_pkg::FN_TCP, cpu_pkg::FN_SHL, cpu_pkg::FN_SHR: begin
                        alu_op = cpu_pkg::alu_op_e'(func[2:0]);
                        wr_en  = 1'b1;
                    end
                    cpu_pkg::FN_WWD: is_wwd = 1'b1;
                    cpu_pkg::FN_HLT: is_hlt = 1'b1;
                    default: ;                   // no-op, still counted
                endcase
            end
            default: ;
        endcase
    end

    alu u_alu (
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_result (alu_result)
    );

    //////////////////////////////
    // retire and write-back

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            num_inst    <= '0;
            output_port <= '0;
            is_halted   <= 1'b0;
        end else if (retire) begin
            num_inst <= num_inst + `WORD_SIZE'(1);
            if (wr_en)  regs[wr_idx] <= alu_result;
            if (is_wwd) output_port  <= rs_val;
            if (is_hlt) is_halted    <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: cpu.sv
`include "cpu_macros.svh"
`timescale 1ns/10ps
`default_nettype none

module cpu (
    input  wire                  clk,
    input  wire                  reset_n,
    input  wire cpu_pkg::word_t  data1,
    input  wire                  m1_ready,
    output logic                 read_m1,
    output cpu_pkg::word_t       address1,
    output cpu_pkg::word_t       num_inst,
    output cpu_pkg::word_t       output_port,
    output logic                 is_halted
);

    // fetch -> queue
    logic           fetch_valid;
    logic           fetch_ready;
    cpu_pkg::word_t fetch_word;

    // queue -> execute
    logic           inst_valid;
    logic           inst_ready;
    cpu_pkg::word_t inst_word;

    inst_fetch u_fetch (
        .clk         (clk),
        .reset_n     (reset_n),
        .m1_ready    (m1_ready),
        .data1       (data1),
        .fetch_ready (fetch_ready),
        .read_m1     (read_m1),
        .address1    (address1),
        .fetch_valid (fetch_valid),
        .fetch_word  (fetch_word)
    );

    inst_queue u_queue (
        .clk         (clk),
        .reset_n     (reset_n),
        .fetch_valid (fetch_valid),
        .fetch_word  (fetch_word),
        .inst_ready  (inst_ready),
        .fetch_ready (fetch_ready),
        .inst_valid  (inst_valid),
        .inst_word   (inst_word)
    );

    exec_unit u_exec (
        .clk         (clk),
        .reset_n     (reset_n),
        .inst_valid  (inst_valid),
        .inst_word   (inst_word),
        .inst_ready  (inst_ready),
        .num_inst    (num_inst),
        .output_port (output_port),
        .is_halted   (is_halted)
    );

endmodule

`default_nettype wire

// File: cpu_chk.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_chk (
    input wire                 clk,
    input wire                 reset_n,
    input wire                 read_m1,
    input wire                 m1_ready,
    input wire cpu_pkg::word_t address1,
    input wire cpu_pkg::word_t num_inst,
    input wire                 is_halted
);

    //////////////////////////////
    // fetch port

    a_addr_hold: assert property (@(posedge clk) disable iff (reset_n)
        (read_m1 && !m1_ready) |=> $stable(address1))
        else $error("address1 changed while a read was still pending");

    a_no_read_in_reset: assert property (@(posedge clk)
        reset_n |-> !read_m1)
        else $error("read_m1 high while reset is asserted");

    //////////////////////////////
    // halt behavior

    a_halt_sticky: assert property (@(posedge clk) disable iff (reset_n)
        is_halted |=> is_halted)
        else $error("is_halted fell without a reset");

    a_count_frozen: assert property (@(posedge clk) disable iff (reset_n)
        is_halted |=> $stable(num_inst))   // nothing retires after HLT
        else $error("num_inst changed after halt");

endmodule

`default_nettype wire

// File: tb_cpu.sv
`include "cpu_macros.svh"
`timescale 1ns/10ps
`default_nettype none

module tb_cpu;

    localparam int NUM_TESTS = 6;
    localparam int TIMEOUT   = 2000;
    localparam int MAX_PROG  = 60;
    localparam cpu_pkg::word_t HLT_WORD = 16'hF01D;   // R-type with func 29

    logic           clk;
    logic           reset_n;
    cpu_pkg::word_t data1;
    logic           m1_ready;
    logic           read_m1;
    cpu_pkg::word_t address1;
    cpu_pkg::word_t num_inst;
    cpu_pkg::word_t output_port;
    logic           is_halted;

    cpu_pkg::word_t prog [MAX_PROG];
    int             prog_len;
    cpu_pkg::word_t port_changes [$];  // output_port values in order with repeats merged
    int             exp_count;
    cpu_pkg::word_t exp_final;

    bit             mon_on;
    int             next_addr;
    int             port_idx;
    cpu_pkg::word_t last_port;
    int             test_errors;
    int             pass_count;
    int             fail_count;

    cpu u_cpu (
        .clk         (clk),
        .reset_n     (reset_n),
        .data1       (data1),
        .m1_ready    (m1_ready),
        .read_m1     (read_m1),
        .address1    (address1),
        .num_inst    (num_inst),
        .output_port (output_port),
        .is_halted   (is_halted)
    );

    bind cpu cpu_chk u_chk (
        .clk       (clk),
        .reset_n   (reset_n),
        .read_m1   (read_m1),
        .m1_ready  (m1_ready),
        .address1  (address1),
        .num_inst  (num_inst),
        .is_halted (is_halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic cpu_pkg::word_t mem_read(cpu_pkg::word_t addr);
        if (int'(addr) < prog_len) return prog[int'(addr)];
        return HLT_WORD;    // everything past the program
    endfunction

    // instruction memory that stalls about 30 % of cycles
    initial begin
        m1_ready = 1'b0;
        data1    = '0;
        forever begin
            @(posedge clk);
            #1;
            m1_ready = ($urandom_range(99, 0) < 70);
            data1    = mem_read(address1);
        end
    end

    //////////////////////////////
    // program and model

    task automatic build_program();
        int         kind;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        logic [7:0] imm;
        prog_len = int'($urandom_range(MAX_PROG, 20));
        for (int i = 0; i < prog_len - 1; i++) begin
            kind = int'($urandom_range(13, 0));
            rs   = 2'($urandom);
            rt   = 2'($urandom);
            rd   = 2'($urandom);
            imm  = 8'($urandom);
            if (kind == 0) prog[i] = {4'd4, rs, rt, imm};
            else if (kind == 1) prog[i] = {4'd5, rs, rt, imm};
            else if (kind == 2) prog[i] = {4'd6, rs, rt, imm};
            else if (kind <= 10) prog[i] = {4'hF, rs, rt, rd, 6'(kind - 3)};
            else prog[i] = {4'hF, rs, rt, rd, 6'd28};   // WWD
        end
        prog[prog_len - 1] = HLT_WORD;
    endtask

    task automatic run_model();
        cpu_pkg::word_t regs [`REG_COUNT];
        cpu_pkg::word_t w;
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        cpu_pkg::word_t port;
        logic [3:0]     op;
        logic [1:0]     rs;
        logic [1:0]     rt;
        logic [1:0]     rd;
        logic [5:0]     fn;
        logic [7:0]     imm;
        int             pc;
        bit             halted;
        foreach (regs[i]) regs[i] = '0;
        port_changes.delete();
        port      = '0;
        pc        = 0;
        halted    = 1'b0;
        exp_count = 0;
        while (!halted) begin
            w   = mem_read(cpu_pkg::word_t'(pc));
            pc++;
            exp_count++;
            op  = w[`OPCODE_HI:`OPCODE_LO];
            rs  = w[`RS_POS +: 2];
            rt  = w[`RT_POS +: 2];
            rd  = w[`RD_POS +: 2];
            fn  = w[`RD_POS-1:0];
            imm = w[`IMM_SIZE-1:0];
            a   = regs[rs];
            b   = regs[rt];
            case (op)
                4'd4: regs[rt] = a + {{8{imm[7]}}, imm};
                4'd5: regs[rt] = a | {8'h00, imm};
                4'd6: regs[rt] = {imm, 8'h00};
                4'hF: begin
                    case (fn)
                        6'd0: regs[rd] = a + b;
                        6'd1: regs[rd] = a - b;
                        6'd2: regs[rd] = a & b;
                        6'd3: regs[rd] = a | b;
                        6'd4: regs[rd] = ~a;
                        6'd5: regs[rd] = 16'h0000 - a;
                        6'd6: regs[rd] = {a[14:0], 1'b0};
                        6'd7: regs[rd] = {a[15], a[15:1]};
                        6'd28: begin
                            if (a != port) port_changes.push_back(a);
                            port = a;
                        end
                        6'd29: halted = 1'b1;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
        exp_final = port;
    endtask

    //////////////////////////////
    // monitors

    always @(negedge clk) begin
        if (mon_on) begin
            if (read_m1 && m1_ready) begin
                assert (address1 == 16'(next_addr)) else begin
                    $display("Mismatch address1: got 0x%h, expected 0x%h",
                             address1, 16'(next_addr));
                    test_errors++;
                end
                next_addr++;
            end
            if (output_port != last_port) begin
                assert (port_idx < port_changes.size()) else begin
                    $display("output_port changed to 0x%h after the last expected WWD value",
                             output_port);
                    test_errors++;
                end
                if (port_idx < port_changes.size()) begin
                    assert (output_port == port_changes[port_idx]) else begin
                        $display("Mismatch output_port: got 0x%h, expected 0x%h",
                                 output_port, port_changes[port_idx]);
                        test_errors++;
                    end
                end
                port_idx++;
                last_port = output_port;
            end
        end
    end

    task automatic check_word(string name, cpu_pkg::word_t got, cpu_pkg::word_t exp);
        assert (got == exp) else begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic apply_reset();
        mon_on = 1'b0;
        @(posedge clk);
        #1;
        reset_n = 1'b1;
        repeat (5) begin
            @(negedge clk);
            assert (read_m1 == 1'b0) else begin
                $display("read_m1 is high while reset is asserted");
                test_errors++;
            end
        end
        @(posedge clk);
        #1;
        next_addr = 0;
        port_idx  = 0;
        last_port = '0;
        reset_n   = 1'b0;
        mon_on    = 1'b1;
        @(negedge clk);
        check_word("is_halted", 16'(is_halted), 16'h0000);
        check_word("num_inst", num_inst, 16'h0000);
        check_word("output_port", output_port, 16'h0000);
    endtask

    task automatic run_test(int t);
        int             cycles;
        int             ready_cycles;
        test_errors = 0;
        build_program();
        run_model();
        apply_reset();
        cycles = 0;
        while (!is_halted && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        assert (is_halted) else begin
            $display("test %0d: is_halted did not rise within %0d cycles", t, TIMEOUT);
            test_errors++;
        end
        if (is_halted) begin
            check_word("num_inst", num_inst, 16'(exp_count));
            cycles       = 0;
            ready_cycles = 0;
            // stall cycles don't count toward the bound
            while (read_m1 && ready_cycles <= `QUEUE_DEPTH + 3 && cycles < TIMEOUT) begin
                if (m1_ready) ready_cycles++;
                @(negedge clk);
                cycles++;
            end
            assert (!read_m1) else begin
                $display("test %0d: read_m1 still high well after halt", t);
                test_errors++;
            end
            repeat (20) begin
                @(negedge clk);
                check_word("num_inst", num_inst, 16'(exp_count));
                assert (is_halted) else begin
                    $display("test %0d: is_halted dropped after halt", t);
                    test_errors++;
                end
            end
            check_word("output_port", output_port, exp_final);
            assert (port_idx == port_changes.size()) else begin
                $display("test %0d: saw %0d output_port changes, expected %0d",
                         t, port_idx, port_changes.size());
                test_errors++;
            end
        end
        mon_on = 1'b0;
        if (test_errors == 0) pass_count++;
        else fail_count++;
        $display("test %0d: %0d instructions, %0d port changes, %0d errors -> %s",
                 t, exp_count, port_changes.size(), test_errors,
                 (test_errors == 0) ? "ok" : "FAIL");
    endtask

    initial begin
        reset_n    = 1'b1;
        mon_on     = 1'b0;
        pass_count = 0;
        fail_count = 0;
        void'($urandom(32'h50301890));
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
cpu_pkg.sv
alu.sv
inst_fetch.sv
inst_queue.sv
exec_unit.sv
cpu.sv
cpu_chk.sv
tb_cpu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f sim.f -o tb_cpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_cpu_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0
